// ==== src/dcache_macros.svh ====
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ---------------------------------------------------------------------------
// Cache geometry.
// ---------------------------------------------------------------------------

`define DCACHE_ADDR_W    32
`define DCACHE_REG_W     64
`define DCACHE_BLOCK_W   512
`define DCACHE_SET_COUNT 2
`define DCACHE_WAYS      2
`define DCACHE_WORD_W    32

// Derived address field widths.
`define DCACHE_WORD_OFF_W ($clog2(`DCACHE_BLOCK_W / `DCACHE_WORD_W))
`define DCACHE_BYTE_OFF_W ($clog2(`DCACHE_WORD_W / 8))
`define DCACHE_INDEX_W    ($clog2(`DCACHE_SET_COUNT))
`define DCACHE_WAY_W      ($clog2(`DCACHE_WAYS))
`define DCACHE_TAG_W      (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_WORD_OFF_W - \
                           `DCACHE_BYTE_OFF_W)

`endif

// ==== src/dcache_pkg.sv ====
`include "dcache_macros.svh"

package dcache_pkg;

    // -----------------------------------------------------------------------
    // Address fields.
    // -----------------------------------------------------------------------

    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_WAY_W-1:0]   way_t;

    // MSB to LSB: tag, set index, word in line, byte in word.
    typedef struct packed {
        tag_t                          tag;
        index_t                        index;
        logic [`DCACHE_WORD_OFF_W-1:0] word_off;
        logic [`DCACHE_BYTE_OFF_W-1:0] byte_off;
    } addr_t;

    // -----------------------------------------------------------------------
    // Payloads.
    // -----------------------------------------------------------------------

    typedef logic [`DCACHE_REG_W-1:0]   reg_t;
    typedef logic [`DCACHE_BLOCK_W-1:0] block_t;

    // Store size, as encoded by the core.
    typedef enum logic [1:0] {
        ST_B = 2'd0,
        ST_H = 2'd1,
        ST_W = 2'd2,
        ST_D = 2'd3
    } store_type_e;

endpackage

// ==== src/dcache_way_array.sv ====
`timescale 1ns/1ps

`include "dcache_macros.svh"

module dcache_way_array
    import dcache_pkg::*;
#(
    parameter type entry_t = logic
) (
    input  logic   clk,

    // Write port.
    input  logic   i_we,
    input  index_t i_index,
    input  way_t   i_way,
    input  entry_t i_wdata,

    // Both ways of the set at i_index.
    output entry_t o_rdata [`DCACHE_WAYS]
);

    entry_t mem [`DCACHE_SET_COUNT][`DCACHE_WAYS];

    // ---------------------------------------------------------------------------
    // Write.
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_index][i_way] <= i_wdata;
        end
    end

    // ---------------------------------------------------------------------------
    // Read.
    // ---------------------------------------------------------------------------

    // Asynchronous read of the whole set.
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            o_rdata[w] = mem[i_index][w];
        end
    end

endmodule

// ==== src/dcache_way_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_macros.svh"

module dcache_way_ctrl
    import dcache_pkg::*;
(
    input  logic  clk,
    input  logic  arst,

    // Strobes from the cache controller.
    input  logic  i_write_en,
    input  logic  i_block_write_en,
    input  logic  i_valid_update,
    input  logic  i_lru_update,
    input  logic  i_addr_control,

    // Request address and the stored tags at its index.
    input  addr_t i_addr,
    input  tag_t  i_tags [`DCACHE_WAYS],

    output logic  o_hit,
    output logic  o_refill,
    output logic  o_dirty,
    output way_t  o_match_way,
    output way_t  o_victim_way,
    output addr_t o_addr_axi
);

    logic [`DCACHE_WAYS-1:0] valid_q [`DCACHE_SET_COUNT];
    logic [`DCACHE_WAYS-1:0] dirty_q [`DCACHE_SET_COUNT];
    way_t                    lru_q   [`DCACHE_SET_COUNT];

    logic [`DCACHE_WAYS-1:0] way_hit;
    way_t                    match_way;
    way_t                    victim_way;
    logic                    refill;

    // ---------------------------------------------------------------------------
    // Lookup.
    // ---------------------------------------------------------------------------

    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            way_hit[w] = valid_q[i_addr.index][w] & (i_tags[w] == i_addr.tag);
        end
    end

    // LRU bit names the way to replace.
    assign victim_way = lru_q[i_addr.index];

    // Lowest hitting way wins, victim on a miss.
    always_comb begin
        match_way = victim_way;
        for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                match_way = way_t'(w);
            end
        end
    end

    // Store has priority over a block write.
    assign refill = i_block_write_en & ~i_write_en;

    // ---------------------------------------------------------------------------
    // Valid, dirty and LRU state.
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            valid_q <= '{default: '0};
        end else if (i_valid_update) begin
            valid_q[i_addr.index][victim_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            dirty_q <= '{default: '0};
        end else if (i_write_en) begin
            dirty_q[i_addr.index][match_way] <= 1'b1;
        end else if (refill) begin
            dirty_q[i_addr.index][victim_way] <= 1'b0;
        end
    end

    // Point at the way not just used.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            lru_q <= '{default: '0};
        end else if (i_lru_update) begin
            lru_q[i_addr.index] <= ~match_way;
        end
    end

    // ---------------------------------------------------------------------------
    // Outputs.
    // ---------------------------------------------------------------------------

    // Line address, refill or writeback.
    always_comb begin
        o_addr_axi       = '0;
        o_addr_axi.index = i_addr.index;
        o_addr_axi.tag   = i_addr_control ? i_addr.tag : i_tags[victim_way];
    end

    assign o_hit        = |way_hit;
    assign o_dirty      = dirty_q[i_addr.index][victim_way];
    assign o_refill     = refill;
    assign o_match_way  = match_way;
    assign o_victim_way = victim_way;

    // Controller only stores into a line already present.
    a_store_on_hit : assert property (@(posedge clk) disable iff (arst)
        i_write_en |-> o_hit)
        else $error("store strobe raised on a cache miss");

endmodule

// ==== src/dcache_data_path.sv ====
`timescale 1ns/1ps

`include "dcache_macros.svh"

module dcache_data_path
    import dcache_pkg::*;
(
    input  logic        i_write_en,
    input  logic        i_refill,
    input  addr_t       i_addr,
    input  store_type_e i_store_type,
    input  reg_t        i_data,
    input  block_t      i_data_block,

    // Both lines of the addressed set.
    input  block_t      i_blocks [`DCACHE_WAYS],
    input  way_t        i_match_way,
    input  way_t        i_victim_way,

    // Data array write port.
    output logic        o_we,
    output way_t        o_wway,
    output block_t      o_wdata,

    output reg_t        o_data,
    output block_t      o_data_block,
    output logic        o_store_addr_ma
);

    block_t                                  hit_line;
    block_t                                  merged;
    logic [`DCACHE_BLOCK_W+`DCACHE_REG_W-1:0] load_ext;
    logic [5:0]                              byte_sel;
    logic [4:0]                              half_sel;

    assign hit_line = i_blocks[i_match_way];
    assign byte_sel = {i_addr.word_off, i_addr.byte_off};
    assign half_sel = {i_addr.word_off, i_addr.byte_off[1]};

    // ---------------------------------------------------------------------------
    // Store merge.
    // ---------------------------------------------------------------------------

    always_comb begin
        merged = hit_line;
        case (i_store_type)
            ST_B: merged[byte_sel*8 +: 8]             = i_data[7:0];
            ST_H: merged[half_sel*16 +: 16]           = i_data[15:0];
            ST_W: merged[i_addr.word_off*32 +: 32]    = i_data[31:0];
            ST_D: merged[i_addr.word_off[3:1]*64 +: 64] = i_data;
            default: merged = hit_line;
        endcase
    end

    // ---------------------------------------------------------------------------
    // Load select.
    // ---------------------------------------------------------------------------

    // Zero padding covers the last word.
    assign load_ext = {{`DCACHE_REG_W{1'b0}}, hit_line};
    assign o_data   = load_ext[i_addr.word_off*32 +: 64];

    assign o_data_block = i_blocks[i_victim_way];

    // ---------------------------------------------------------------------------
    // Misalignment and write steering.
    // ---------------------------------------------------------------------------

    always_comb begin
        case (i_store_type)
            ST_H:    o_store_addr_ma = i_addr.byte_off[0];
            ST_W:    o_store_addr_ma = |i_addr.byte_off;
            ST_D:    o_store_addr_ma = (|i_addr.byte_off) | i_addr.word_off[0];
            default: o_store_addr_ma = 1'b0;
        endcase
    end

    assign o_we    = i_write_en | i_refill;
    assign o_wway  = i_write_en ? i_match_way : i_victim_way;
    assign o_wdata = i_write_en ? merged : i_data_block;

    // Controller traps misaligned stores before the write.
    always_comb begin
        a_store_aligned : assert (!(i_write_en && o_store_addr_ma))
            else $error("store strobe raised with a misaligned address");
    end

endmodule

// ==== src/dcache_top.sv ====
`timescale 1ns/1ps

`include "dcache_macros.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic        clk,
    input  logic        arst,

    // Strobes from the cache controller.
    input  logic        i_write_en,
    input  logic        i_block_write_en,
    input  logic        i_valid_update,
    input  logic        i_lru_update,
    input  logic        i_addr_control,

    // Request.
    input  addr_t       i_addr,
    input  reg_t        i_data,
    input  block_t      i_data_block,
    input  store_type_e i_store_type,

    output reg_t        o_data,
    output block_t      o_data_block,
    output logic        o_hit,
    output logic        o_dirty,
    output logic        o_store_addr_ma,
    output addr_t       o_addr_axi
);

    tag_t   tags   [`DCACHE_WAYS];
    block_t blocks [`DCACHE_WAYS];

    way_t   match_way;
    way_t   victim_way;
    logic   refill;

    logic   data_we;
    way_t   data_wway;
    block_t data_wdata;

    // ---------------------------------------------------------------------------
    // Storage.
    // ---------------------------------------------------------------------------

    dcache_way_array #(.entry_t(tag_t)) u_tag_array (
        .clk     (clk),
        .i_we    (refill),
        .i_index (i_addr.index),
        .i_way   (victim_way),
        .i_wdata (i_addr.tag),
        .o_rdata (tags)
    );

    dcache_way_array #(.entry_t(block_t)) u_data_array (
        .clk     (clk),
        .i_we    (data_we),
        .i_index (i_addr.index),
        .i_way   (data_wway),
        .i_wdata (data_wdata),
        .o_rdata (blocks)
    );

    // ---------------------------------------------------------------------------
    // Control and data.
    // ---------------------------------------------------------------------------

    dcache_way_ctrl u_way_ctrl (
        .clk              (clk),
        .arst             (arst),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .i_valid_update   (i_valid_update),
        .i_lru_update     (i_lru_update),
        .i_addr_control   (i_addr_control),
        .i_addr           (i_addr),
        .i_tags           (tags),
        .o_hit            (o_hit),
        .o_refill         (refill),
        .o_dirty          (o_dirty),
        .o_match_way      (match_way),
        .o_victim_way     (victim_way),
        .o_addr_axi       (o_addr_axi)
    );

    dcache_data_path u_data_path (
        .i_write_en      (i_write_en),
        .i_refill        (refill),
        .i_addr          (i_addr),
        .i_store_type    (i_store_type),
        .i_data          (i_data),
        .i_data_block    (i_data_block),
        .i_blocks        (blocks),
        .i_match_way     (match_way),
        .i_victim_way    (victim_way),
        .o_we            (data_we),
        .o_wway          (data_wway),
        .o_wdata         (data_wdata),
        .o_data          (o_data),
        .o_data_block    (o_data_block),
        .o_store_addr_ma (o_store_addr_ma)
    );

endmodule

// ==== test/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb
    import dcache_pkg::*;
();

    // Strobe bit order is {we, block_we, valid_update, lru_update, addr_control}.
    localparam logic [4:0] S_NONE = 5'b00000;
    localparam logic [4:0] S_WE   = 5'b10000;
    localparam logic [4:0] S_BWE  = 5'b01000;
    localparam logic [4:0] S_VU   = 5'b00100;
    localparam logic [4:0] S_LU   = 5'b00010;
    localparam logic [4:0] S_AC   = 5'b00001;

    localparam logic [5:0] CHK_HIT   = 6'b000001;
    localparam logic [5:0] CHK_DIRTY = 6'b000010;
    localparam logic [5:0] CHK_DATA  = 6'b000100;
    localparam logic [5:0] CHK_MA    = 6'b001000;
    localparam logic [5:0] CHK_AXI   = 6'b010000;
    localparam logic [5:0] CHK_BLOCK = 6'b100000;

    localparam tag_t TAG_A = 25'h00000ab;
    localparam tag_t TAG_B = 25'h0001234;
    localparam tag_t TAG_C = 25'h0000567;
    localparam tag_t TAG_D = 25'h0000bcd;

    typedef struct {
        logic [4:0]  strobes;
        addr_t       addr;
        reg_t        data;
        logic [7:0]  base;
        store_type_e st;
        logic        exp_hit;
        logic        exp_dirty;
        reg_t        exp_data;
        logic        exp_ma;
        addr_t       exp_axi;
        block_t      exp_block;
        logic [5:0]  mask;
    } row_t;

    logic        clk;
    logic        arst;
    logic        i_write_en;
    logic        i_block_write_en;
    logic        i_valid_update;
    logic        i_lru_update;
    logic        i_addr_control;
    addr_t       i_addr;
    reg_t        i_data;
    block_t      i_data_block;
    store_type_e i_store_type;
    reg_t        o_data;
    block_t      o_data_block;
    logic        o_hit;
    logic        o_dirty;
    logic        o_store_addr_ma;
    addr_t       o_addr_axi;

    row_t rows [$];
    int   cycles;
    int   cycle_limit;
    int   row_idx;

    dcache_top uut (
        .clk              (clk),
        .arst             (arst),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .i_valid_update   (i_valid_update),
        .i_lru_update     (i_lru_update),
        .i_addr_control   (i_addr_control),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_data_block     (i_data_block),
        .i_store_type     (i_store_type),
        .o_data           (o_data),
        .o_data_block     (o_data_block),
        .o_hit            (o_hit),
        .o_dirty          (o_dirty),
        .o_store_addr_ma  (o_store_addr_ma),
        .o_addr_axi       (o_addr_axi)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the table did not finish", cycles);
            $display("Simulation failed");
            $fatal(1, "cycle limit reached");
        end
    end

    // ------------------------------------------------------------------------
    // Helpers.
    // ------------------------------------------------------------------------

    function automatic addr_t addr_of(tag_t tag, index_t index, logic [3:0] word,
                                      logic [1:0] bo);
        return {tag, index, word, bo};
    endfunction

    // Line address has both offsets zero.
    function automatic addr_t line_addr(tag_t tag, index_t index);
        return {tag, index, 6'b0};
    endfunction

    // Byte i of the line holds base + i.
    function automatic block_t make_block(logic [7:0] base);
        block_t blk;
        for (int i = 0; i < 64; i++) begin
            blk[i*8 +: 8] = base + 8'(i);
        end
        return blk;
    endfunction

    task automatic add_row(logic [4:0] strobes, addr_t addr, reg_t data, logic [7:0] base,
                           store_type_e st, logic hit, logic dirty, reg_t exp_data,
                           logic ma, addr_t axi, logic [5:0] mask,
                           block_t exp_block = '0);
        row_t r;
        r.strobes   = strobes;
        r.addr      = addr;
        r.data      = data;
        r.base      = base;
        r.st        = st;
        r.exp_hit   = hit;
        r.exp_dirty = dirty;
        r.exp_data  = exp_data;
        r.exp_ma    = ma;
        r.exp_axi   = axi;
        r.exp_block = exp_block;
        r.mask      = mask;
        rows.push_back(r);
    endtask

    task automatic add_ma_row(logic [3:0] word, logic [1:0] bo, store_type_e st, logic ma);
        add_row(S_NONE, addr_of(TAG_A, 0, word, bo), 64'h0, 8'h00, st,
                0, 0, 64'h0, ma, 32'h0, CHK_MA);
    endtask

    task automatic check_value(string name, block_t expected, block_t actual);
        assert (actual === expected) else begin
            $display("FAILED at time %0t: row %0d, %s expected 0x%0h, actual 0x%0h",
                     $time, row_idx, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "wrong value on %s", name);
        end
    endtask

    // Drive on the falling edge and sample just before the next rising edge.
    task automatic apply_row(row_t r);
        @(negedge clk);
        {i_write_en, i_block_write_en, i_valid_update, i_lru_update, i_addr_control}
            = r.strobes;
        i_addr       = r.addr;
        i_data       = r.data;
        i_data_block = make_block(r.base);
        i_store_type = r.st;
        #40;
        if ((r.mask & CHK_HIT) != 0) check_value("o_hit", 64'(r.exp_hit), 64'(o_hit));
        if ((r.mask & CHK_DIRTY) != 0) check_value("o_dirty", 64'(r.exp_dirty), 64'(o_dirty));
        if ((r.mask & CHK_DATA) != 0) check_value("o_data", r.exp_data, o_data);
        if ((r.mask & CHK_MA) != 0) begin
            check_value("o_store_addr_ma", 64'(r.exp_ma), 64'(o_store_addr_ma));
        end
        if ((r.mask & CHK_AXI) != 0) begin
            check_value("o_addr_axi", 64'(r.exp_axi), 64'(o_addr_axi));
        end
        if ((r.mask & CHK_BLOCK) != 0) begin
            check_value("o_data_block", r.exp_block, o_data_block);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table.
    // ------------------------------------------------------------------------

    task automatic build_table();
        block_t wb_line;

        // Way 1 of set 1 after the word store at word 2.
        wb_line              = make_block(8'h80);
        wb_line[2*32 +: 32]  = 32'hcafef00d;

        // Empty cache.
        add_row(S_AC, addr_of(TAG_A, 0, 0, 0), 64'h0, 8'h00, ST_B,
                0, 0, 64'h0, 0, line_addr(TAG_A, 0), CHK_HIT | CHK_DIRTY | CHK_AXI);
        // Refill set 0 and load from it.
        add_row(S_BWE | S_VU | S_AC, addr_of(TAG_A, 0, 0, 0), 64'h0, 8'h00, ST_B,
                0, 0, 64'h0, 0, line_addr(TAG_A, 0), CHK_HIT | CHK_AXI);
        add_row(S_NONE, addr_of(TAG_A, 0, 0, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h0706050403020100, 0, 32'h0, CHK_HIT | CHK_DIRTY | CHK_DATA);
        add_row(S_NONE, addr_of(TAG_A, 0, 5, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h1b1a191817161514, 0, 32'h0, CHK_HIT | CHK_DATA);
        add_row(S_NONE, addr_of(TAG_A, 0, 15, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h000000003f3e3d3c, 0, 32'h0, CHK_HIT | CHK_DATA);
        // Each store size is read back by a load.
        add_row(S_WE, addr_of(TAG_A, 0, 1, 2), 64'ha5, 8'h00, ST_B,
                1, 0, 64'h0, 0, 32'h0, CHK_HIT | CHK_MA);
        add_row(S_NONE, addr_of(TAG_A, 0, 0, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h07a5050403020100, 0, 32'h0, CHK_HIT | CHK_DIRTY | CHK_DATA);
        add_row(S_WE, addr_of(TAG_A, 0, 3, 2), 64'hbeef, 8'h00, ST_H,
                1, 0, 64'h0, 0, 32'h0, CHK_HIT | CHK_MA);
        add_row(S_NONE, addr_of(TAG_A, 0, 3, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h13121110beef0d0c, 0, 32'h0, CHK_HIT | CHK_DATA);
        add_row(S_WE, addr_of(TAG_A, 0, 7, 0), 64'hdeadbeef, 8'h00, ST_W,
                1, 0, 64'h0, 0, 32'h0, CHK_HIT | CHK_MA);
        add_row(S_NONE, addr_of(TAG_A, 0, 7, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h23222120deadbeef, 0, 32'h0, CHK_HIT | CHK_DATA);
        add_row(S_WE, addr_of(TAG_A, 0, 10, 0), 64'h0123456789abcdef, 8'h00, ST_D,
                1, 0, 64'h0, 0, 32'h0, CHK_HIT | CHK_MA);
        add_row(S_NONE, addr_of(TAG_A, 0, 11, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h3332313001234567, 0, 32'h0, CHK_HIT | CHK_DATA);
        // Misalignment.
        add_ma_row(0, 3, ST_B, 0);
        add_ma_row(0, 1, ST_H, 1);
        add_ma_row(0, 2, ST_H, 0);
        add_ma_row(4, 2, ST_W, 1);
        add_ma_row(4, 1, ST_W, 1);
        add_ma_row(4, 0, ST_W, 0);
        add_ma_row(3, 0, ST_D, 1);
        add_ma_row(2, 0, ST_D, 0);
        add_ma_row(2, 1, ST_D, 1);
        add_ma_row(2, 2, ST_D, 1);
        // Both ways of set 1.
        add_row(S_BWE | S_VU | S_LU, addr_of(TAG_B, 1, 0, 0), 64'h0, 8'h40, ST_B,
                0, 0, 64'h0, 0, 32'h0, CHK_HIT);
        add_row(S_BWE | S_VU | S_LU, addr_of(TAG_C, 1, 0, 0), 64'h0, 8'h80, ST_B,
                0, 0, 64'h0, 0, 32'h0, CHK_HIT);
        add_row(S_LU, addr_of(TAG_B, 1, 0, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h4746454443424140, 0, 32'h0, CHK_HIT | CHK_DATA);
        add_row(S_NONE, addr_of(TAG_C, 1, 1, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h8b8a898887868584, 0, line_addr(TAG_C, 1),
                CHK_HIT | CHK_DIRTY | CHK_DATA | CHK_AXI);
        add_row(S_WE, addr_of(TAG_C, 1, 2, 0), 64'hcafef00d, 8'h00, ST_W,
                1, 0, 64'h0, 0, 32'h0, CHK_HIT | CHK_MA);
        add_row(S_NONE, addr_of(TAG_C, 1, 2, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h8f8e8d8ccafef00d, 0, 32'h0, CHK_HIT | CHK_DIRTY | CHK_DATA);
        add_row(S_AC, addr_of(TAG_B, 1, 0, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h0, 0, line_addr(TAG_B, 1), CHK_HIT | CHK_DIRTY | CHK_AXI);
        add_row(S_NONE, addr_of(TAG_B, 1, 0, 0), 64'h0, 8'h00, ST_B,
                1, 1, 64'h0, 0, line_addr(TAG_C, 1), CHK_AXI | CHK_BLOCK, wb_line);
        // Replace the dirty way.
        add_row(S_BWE | S_VU, addr_of(TAG_D, 1, 0, 0), 64'h0, 8'hc0, ST_B,
                0, 1, 64'h0, 0, line_addr(TAG_C, 1), CHK_HIT | CHK_DIRTY | CHK_AXI);
        add_row(S_NONE, addr_of(TAG_D, 1, 0, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'hc7c6c5c4c3c2c1c0, 0, line_addr(TAG_D, 1),
                CHK_HIT | CHK_DIRTY | CHK_DATA | CHK_AXI | CHK_BLOCK, make_block(8'hc0));
        add_row(S_NONE, addr_of(TAG_B, 1, 0, 0), 64'h0, 8'h00, ST_B,
                1, 0, 64'h4746454443424140, 0, 32'h0, CHK_HIT | CHK_DATA);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence.
    // ------------------------------------------------------------------------

    initial begin
        clk              = 1'b0;
        arst             = 1'b1;
        i_write_en       = 1'b0;
        i_block_write_en = 1'b0;
        i_valid_update   = 1'b0;
        i_lru_update     = 1'b0;
        i_addr_control   = 1'b0;
        i_addr           = '0;
        i_data           = '0;
        i_data_block     = '0;
        i_store_type     = ST_B;
        cycles           = 0;
        row_idx          = 0;

        build_table();
        cycle_limit = 4 + 2 * rows.size() + 20;

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst = 1'b0;

        foreach (rows[k]) begin
            row_idx = k;
            apply_row(rows[k]);
        end

        @(negedge clk);
        {i_write_en, i_block_write_en, i_valid_update, i_lru_update, i_addr_control} = '0;

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_way_array.sv
src/dcache_way_ctrl.sv
src/dcache_data_path.sv
src/dcache_top.sv
test/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the data cache testbench.

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# Pass only if the testbench printed the pass line.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
